// File: logic/ntt_addr_pkg.sv
/*
 * Shared widths, the software register address enum and the one-hot
 * write select type for the NTT address unit
 */

package ntt_addr_pkg;

    // Index registers and their word-select field
    localparam int unsigned idx_width  = 8;
    localparam int unsigned wsel_width = 3;

    // Modular coordinate counters
    localparam int unsigned coord_width = 3;

    // Software access data path
    localparam int unsigned ispr_data_width = 32;
    localparam int unsigned ispr_num        = 8;

    typedef logic [idx_width-1:0]   idx_t;
    typedef logic [coord_width-1:0] coord_t;

    // Software-visible registers, also the opcode of an access
    typedef enum logic [2:0] {
        ispr_m    = 3'd0,
        ispr_j2   = 3'd1,
        ispr_j    = 3'd2,
        ispr_idx0 = 3'd3,
        ispr_idx1 = 3'd4,
        ispr_mode = 3'd5,
        ispr_x    = 3'd6,
        ispr_y    = 3'd7
    } ispr_addr_e;

    // One bit per register, indexed by ispr_addr_e
    typedef logic [ispr_num-1:0] ispr_sel_t;

endpackage

// File: logic/ispr_bus_if.sv
/*
 * Decoded software write bus from the access port to the register blocks
 */

`timescale 1ns/1ns

interface ispr_bus_if;

    import ntt_addr_pkg::*;

    // Clear strobe for every register
    logic      init;
    // One-hot register select, zero when no write
    ispr_sel_t wr_sel;
    // Low byte of the software write data
    idx_t      wdata;

    modport source (
        output init,
        output wr_sel,
        output wdata
    );

    modport sink (
        input init,
        input wr_sel,
        input wdata
    );

endinterface

// File: logic/addr_state_if.sv
/*
 * Current loop and index register values shared between the blocks
 */

`timescale 1ns/1ns

interface addr_state_if;

    import ntt_addr_pkg::*;

    // Loop state
    idx_t   m;
    idx_t   j2;
    idx_t   j;
    logic   mode;

    // Operand indices and coordinates
    idx_t   idx0;
    idx_t   idx1;
    coord_t x;
    coord_t y;

    modport loop_side (
        output m,
        output j2,
        output j,
        output mode
    );

    modport index_side (
        input  m,
        input  j,
        output idx0,
        output idx1,
        output x,
        output y
    );

    modport read_side (
        input m,
        input j2,
        input j,
        input mode,
        input idx0,
        input idx1,
        input x,
        input y
    );

endinterface

// File: logic/ispr_port.sv
/*
 * Software access port: write select decode and read data multiplexer
 */

`timescale 1ns/1ns

module ispr_port (
    input  ntt_addr_pkg::ispr_addr_e                  ispr_addr_i,
    input  logic [ntt_addr_pkg::ispr_data_width-1:0]  ispr_wdata_i,
    input  logic                                      ispr_wr_en_i,
    input  logic                                      ispr_init_i,
    output logic [ntt_addr_pkg::ispr_data_width-1:0]  ispr_rdata_o,

    ispr_bus_if.source                                bus,
    addr_state_if.read_side                           state
);

    import ntt_addr_pkg::*;

    // Init and data go straight out, registers pick their own priority
    assign bus.init  = ispr_init_i;
    assign bus.wdata = ispr_wdata_i[idx_width-1:0];

    // Address to one-hot select, gated by the write strobe
    always_comb begin
        bus.wr_sel = '0;
        if (ispr_wr_en_i) begin
            bus.wr_sel[ispr_addr_i] = 1'b1;
        end
    end

    // Read data from the registered values, zero extended
    always_comb begin
        ispr_rdata_o = '0;
        unique case (ispr_addr_i)
            ispr_m: begin
                ispr_rdata_o = ispr_data_width'(state.m);
            end
            ispr_j2: begin
                ispr_rdata_o = ispr_data_width'(state.j2);
            end
            ispr_j: begin
                ispr_rdata_o = ispr_data_width'(state.j);
            end
            ispr_idx0: begin
                ispr_rdata_o = ispr_data_width'(state.idx0);
            end
            ispr_idx1: begin
                ispr_rdata_o = ispr_data_width'(state.idx1);
            end
            ispr_mode: begin
                ispr_rdata_o = ispr_data_width'(state.mode);
            end
            ispr_x: begin
                ispr_rdata_o = ispr_data_width'(state.x);
            end
            ispr_y: begin
                ispr_rdata_o = ispr_data_width'(state.y);
            end
            default: begin
                ispr_rdata_o = '0;
            end
        endcase
    end

endmodule

// File: logic/loop_regs.sv
/*
 * Loop state registers m, j2, j and mode with the stride shifts
 * and the loop counter increment
 */

`timescale 1ns/1ns

module loop_regs (
    input  logic             clk_i,
    input  logic             rst_i,

    input  logic             sl_m_i,
    input  logic             sl_j2_i,
    input  logic             inc_j_i,

    ispr_bus_if.sink         bus,
    addr_state_if.loop_side  state
);

    import ntt_addr_pkg::*;

    idx_t m_q;
    idx_t j2_q;
    idx_t j_q;
    logic mode_q;

    idx_t m_shifted;
    idx_t j2_shifted;

    // mode 1: m moves up, j2 moves down; mode 0 the other way round
    assign m_shifted  = mode_q ? {m_q[idx_width-2:0], 1'b0} : {1'b0, m_q[idx_width-1:1]};
    assign j2_shifted = mode_q ? {1'b0, j2_q[idx_width-1:1]} : {j2_q[idx_width-2:0], 1'b0};

    // Stride register
    always_ff @(posedge clk_i) begin
        if (rst_i || bus.init) begin
            m_q <= '0;
        end else if (bus.wr_sel[ispr_m]) begin
            m_q <= bus.wdata;
        end else if (sl_m_i) begin
            m_q <= m_shifted;
        end
    end

    // Inner stride register
    always_ff @(posedge clk_i) begin
        if (rst_i || bus.init) begin
            j2_q <= '0;
        end else if (bus.wr_sel[ispr_j2]) begin
            j2_q <= bus.wdata;
        end else if (sl_j2_i) begin
            j2_q <= j2_shifted;
        end
    end

    // Loop counter, wraps at 256
    always_ff @(posedge clk_i) begin
        if (rst_i || bus.init) begin
            j_q <= '0;
        end else if (bus.wr_sel[ispr_j]) begin
            j_q <= bus.wdata;
        end else if (inc_j_i) begin
            j_q <= j_q + 1'b1;
        end
    end

    // Shift direction, software only
    always_ff @(posedge clk_i) begin
        if (rst_i || bus.init) begin
            mode_q <= 1'b0;
        end else if (bus.wr_sel[ispr_mode]) begin
            mode_q <= bus.wdata[0];
        end
    end

    assign state.m    = m_q;
    assign state.j2   = j2_q;
    assign state.j    = j_q;
    assign state.mode = mode_q;

endmodule

// File: logic/index_gen.sv
/*
 * Operand index registers idx0 and idx1, bit-reversed index setup
 * and the modular x and y coordinate counters
 */

`timescale 1ns/1ns

module index_gen #(
    parameter int unsigned xy_modulus = 5
) (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic              set_idx_i,
    input  logic              inc_idx_i,
    input  logic              inc_x_i,
    input  logic              inc_y_i,

    ispr_bus_if.sink          bus,
    addr_state_if.index_side  state
);

    import ntt_addr_pkg::*;

    // Modulus at the width of the counter sum
    localparam logic [coord_width:0] mod_val = (coord_width + 1)'(xy_modulus);

    idx_t   idx0_q;
    idx_t   idx1_q;
    coord_t x_q;
    coord_t y_q;

    idx_t   j_rev;
    idx_t   idx1_base;
    coord_t x_step;
    coord_t y_step;

    // Add one with a single conditional subtract, so 7 steps to 3 for modulus 5
    function automatic coord_t step_coord(coord_t val);
        logic [coord_width:0] sum;
        sum = {1'b0, val} + 1'b1;
        if (sum >= mod_val) begin
            sum = sum - mod_val;
        end
        return sum[coord_width-1:0];
    endfunction

    // Bit reversal of j over the full index width
    always_comb begin
        for (int i = 0; i < idx_width; i++) begin
            j_rev[i] = state.j[idx_width-1-i];
        end
    end

    // Second operand sits m above the first, mod 256
    assign idx1_base = j_rev + state.m;

    assign x_step = step_coord(x_q);
    assign y_step = step_coord(y_q);

    // Operand indices, set beats increment
    always_ff @(posedge clk_i) begin
        if (rst_i || bus.init) begin
            idx0_q <= '0;
        end else if (bus.wr_sel[ispr_idx0]) begin
            idx0_q <= bus.wdata;
        end else if (set_idx_i) begin
            idx0_q <= j_rev;
        end else if (inc_idx_i) begin
            idx0_q <= idx0_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || bus.init) begin
            idx1_q <= '0;
        end else if (bus.wr_sel[ispr_idx1]) begin
            idx1_q <= bus.wdata;
        end else if (set_idx_i) begin
            idx1_q <= idx1_base;
        end else if (inc_idx_i) begin
            idx1_q <= idx1_q + 1'b1;
        end
    end

    // Coordinate counters
    always_ff @(posedge clk_i) begin
        if (rst_i || bus.init) begin
            x_q <= '0;
        end else if (bus.wr_sel[ispr_x]) begin
            x_q <= bus.wdata[coord_width-1:0];
        end else if (inc_x_i) begin
            x_q <= x_step;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || bus.init) begin
            y_q <= '0;
        end else if (bus.wr_sel[ispr_y]) begin
            y_q <= bus.wdata[coord_width-1:0];
        end else if (inc_y_i) begin
            y_q <= y_step;
        end
    end

    assign state.idx0 = idx0_q;
    assign state.idx1 = idx1_q;
    assign state.x    = x_q;
    assign state.y    = y_q;

endmodule

// File: logic/ntt_addr_unit.sv
/*
 * NTT address unit top level: access port, loop registers and index
 * generator joined by the write bus and the state interface
 */

`timescale 1ns/1ns

module ntt_addr_unit #(
    parameter int unsigned xy_modulus = 5
) (
    input  logic                                      clk_i,
    input  logic                                      rst_i,

    // Loop control strobes
    input  logic                                      sl_m_i,
    input  logic                                      sl_j2_i,
    input  logic                                      inc_j_i,
    input  logic                                      set_idx_i,
    input  logic                                      inc_idx_i,
    input  logic                                      inc_x_i,
    input  logic                                      inc_y_i,

    // Software register access
    input  ntt_addr_pkg::ispr_addr_e                  ispr_addr_i,
    input  logic [ntt_addr_pkg::ispr_data_width-1:0]  ispr_wdata_i,
    input  logic                                      ispr_wr_en_i,
    input  logic                                      ispr_init_i,
    output logic [ntt_addr_pkg::ispr_data_width-1:0]  ispr_rdata_o,

    // Operand addresses and coordinates
    output logic [ntt_addr_pkg::idx_width-ntt_addr_pkg::wsel_width-1:0] wdr0_o,
    output logic [ntt_addr_pkg::wsel_width-1:0]       wsel0_o,
    output logic [ntt_addr_pkg::idx_width-ntt_addr_pkg::wsel_width-1:0] wdr1_o,
    output logic [ntt_addr_pkg::wsel_width-1:0]       wsel1_o,
    output ntt_addr_pkg::coord_t                      x_o,
    output ntt_addr_pkg::coord_t                      y_o
);

    import ntt_addr_pkg::*;

    ispr_bus_if   ispr_bus ();
    addr_state_if addr_state ();

    ispr_port u_ispr_port (
        .ispr_addr_i  (ispr_addr_i),
        .ispr_wdata_i (ispr_wdata_i),
        .ispr_wr_en_i (ispr_wr_en_i),
        .ispr_init_i  (ispr_init_i),
        .ispr_rdata_o (ispr_rdata_o),
        .bus          (ispr_bus.source),
        .state        (addr_state.read_side)
    );

    loop_regs u_loop_regs (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .sl_m_i  (sl_m_i),
        .sl_j2_i (sl_j2_i),
        .inc_j_i (inc_j_i),
        .bus     (ispr_bus.sink),
        .state   (addr_state.loop_side)
    );

    index_gen #(
        .xy_modulus (xy_modulus)
    ) u_index_gen (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .set_idx_i (set_idx_i),
        .inc_idx_i (inc_idx_i),
        .inc_x_i   (inc_x_i),
        .inc_y_i   (inc_y_i),
        .bus       (ispr_bus.sink),
        .state     (addr_state.index_side)
    );

    // Register number in the high bits, word select in the low bits
    assign wdr0_o  = addr_state.idx0[idx_width-1:wsel_width];
    assign wsel0_o = addr_state.idx0[wsel_width-1:0];
    assign wdr1_o  = addr_state.idx1[idx_width-1:wsel_width];
    assign wsel1_o = addr_state.idx1[wsel_width-1:0];

    assign x_o = addr_state.x;
    assign y_o = addr_state.y;

endmodule

// File: sim/ntt_addr_assertions.sv
/*
 * Concurrent checks on the write select decode, the init clear and
 * the x counter range of the NTT address unit
 */

`timescale 1ns/1ns

module ntt_addr_assertions #(
    parameter int unsigned xy_modulus = 5
) (
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      ispr_init_i,
    input logic                      ispr_wr_en_i,
    input ntt_addr_pkg::ispr_addr_e  ispr_addr_i,
    input logic                      inc_x_i,
    input ntt_addr_pkg::ispr_sel_t   wr_sel_i,
    input logic [4:0]                wdr0_i,
    input logic [2:0]                wsel0_i,
    input logic [4:0]                wdr1_i,
    input logic [2:0]                wsel1_i,
    input ntt_addr_pkg::coord_t      x_i,
    input ntt_addr_pkg::coord_t      y_i
);

    import ntt_addr_pkg::*;

    // A write selects just the addressed register and no write selects none
    wr_sel_onehot: assert property (@(posedge clk_i)
        $onehot0(wr_sel_i)
        && (ispr_wr_en_i ? wr_sel_i[ispr_addr_i] : (wr_sel_i == '0)))
        else $error("Write select does not match the write strobe and address");

    init_clears: assert property (@(posedge clk_i)
        ispr_init_i |=> (wdr0_i == '0 && wsel0_i == '0 && wdr1_i == '0
                         && wsel1_i == '0 && x_i == '0 && y_i == '0))
        else $error("Outputs not cleared in the cycle after init");

    // An in-range counter stays in range
    x_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
        (inc_x_i && !wr_sel_i[ispr_x] && 32'(x_i) < xy_modulus) |=> 32'(x_i) < xy_modulus)
        else $error("x counter left its range after an increment");

endmodule

bind ntt_addr_unit ntt_addr_assertions #(
    .xy_modulus (xy_modulus)
) u_assertions (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ispr_init_i  (ispr_init_i),
    .ispr_wr_en_i (ispr_wr_en_i),
    .ispr_addr_i  (ispr_addr_i),
    .inc_x_i      (inc_x_i),
    .wr_sel_i     (ispr_bus.wr_sel),
    .wdr0_i       (wdr0_o),
    .wsel0_i      (wsel0_o),
    .wdr1_i       (wdr1_o),
    .wsel1_i      (wsel1_o),
    .x_i          (x_o),
    .y_i          (y_o)
);

// File: sim/tb_ntt_addr_unit.sv
/*
 * Testbench for the NTT address unit: clock and reset, directed and
 * random stimulus, a shadow register model and per-cycle output checks
 */

`timescale 1ns/1ns

module tb_ntt_addr_unit;

    import ntt_addr_pkg::*;

    localparam int unsigned xy_modulus    = 5;
    localparam int unsigned random_cycles = 2000;
    // Random phase plus a generous margin for reset and the directed tests
    localparam int unsigned timeout_cycles = 3000;
    localparam int unsigned drive_delay    = 2;

    logic        clk_i;
    logic        rst_i;
    logic        sl_m_i;
    logic        sl_j2_i;
    logic        inc_j_i;
    logic        set_idx_i;
    logic        inc_idx_i;
    logic        inc_x_i;
    logic        inc_y_i;
    ispr_addr_e  ispr_addr_i;
    logic [31:0] ispr_wdata_i;
    logic        ispr_wr_en_i;
    logic        ispr_init_i;
    logic [31:0] ispr_rdata_o;
    logic [4:0]  wdr0_o;
    logic [2:0]  wsel0_o;
    logic [4:0]  wdr1_o;
    logic [2:0]  wsel1_o;
    coord_t      x_o;
    coord_t      y_o;

    // Shadow copies of every register
    idx_t   m_exp;
    idx_t   j2_exp;
    idx_t   j_exp;
    logic   mode_exp;
    idx_t   idx0_exp;
    idx_t   idx1_exp;
    coord_t x_exp;
    coord_t y_exp;

    int unsigned cycle_count = 0;

    ntt_addr_unit #(
        .xy_modulus (xy_modulus)
    ) dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .sl_m_i       (sl_m_i),
        .sl_j2_i      (sl_j2_i),
        .inc_j_i      (inc_j_i),
        .set_idx_i    (set_idx_i),
        .inc_idx_i    (inc_idx_i),
        .inc_x_i      (inc_x_i),
        .inc_y_i      (inc_y_i),
        .ispr_addr_i  (ispr_addr_i),
        .ispr_wdata_i (ispr_wdata_i),
        .ispr_wr_en_i (ispr_wr_en_i),
        .ispr_init_i  (ispr_init_i),
        .ispr_rdata_o (ispr_rdata_o),
        .wdr0_o       (wdr0_o),
        .wsel0_o      (wsel0_o),
        .wdr1_o       (wdr1_o),
        .wsel1_o      (wsel1_o),
        .x_o          (x_o),
        .y_o          (y_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("Timeout: the run did not end within %0d cycles", timeout_cycles);
            $display("Test failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    function automatic idx_t bit_reverse(idx_t v);
        idx_t r;
        for (int b = 0; b < idx_width; b++) begin
            r[idx_width-1-b] = v[b];
        end
        return r;
    endfunction

    // Plus one in 4 bits, one subtract of the modulus when it reaches it
    function automatic coord_t coord_step(coord_t v);
        logic [3:0] nxt;
        nxt = 4'(v) + 4'd1;
        if (nxt >= 4'(xy_modulus)) begin
            nxt = nxt - 4'(xy_modulus);
        end
        return nxt[2:0];
    endfunction

    function automatic logic [31:0] expected_rdata(ispr_addr_e a);
        case (a)
            ispr_m:    return 32'(m_exp);
            ispr_j2:   return 32'(j2_exp);
            ispr_j:    return 32'(j_exp);
            ispr_idx0: return 32'(idx0_exp);
            ispr_idx1: return 32'(idx1_exp);
            ispr_mode: return 32'(mode_exp);
            ispr_x:    return 32'(x_exp);
            default:   return 32'(y_exp);
        endcase
    endfunction

    // Applies the inputs sampled at this edge to the shadow registers
    task automatic update_model();
        logic [7:0] hit;
        idx_t       rev;
        hit = ispr_wr_en_i ? 8'(1 << ispr_addr_i) : 8'h00;
        rev = bit_reverse(j_exp);
        if (rst_i || ispr_init_i) begin
            {m_exp, j2_exp, j_exp, mode_exp, idx0_exp, idx1_exp, x_exp, y_exp} = '0;
        end else begin
            // Index updates read the old j and m, shifts read the old mode
            idx0_exp = hit[ispr_idx0] ? ispr_wdata_i[7:0] : set_idx_i ? rev
                     : inc_idx_i ? idx0_exp + 8'd1 : idx0_exp;
            idx1_exp = hit[ispr_idx1] ? ispr_wdata_i[7:0] : set_idx_i ? rev + m_exp
                     : inc_idx_i ? idx1_exp + 8'd1 : idx1_exp;
            x_exp  = hit[ispr_x] ? ispr_wdata_i[2:0] : inc_x_i ? coord_step(x_exp) : x_exp;
            y_exp  = hit[ispr_y] ? ispr_wdata_i[2:0] : inc_y_i ? coord_step(y_exp) : y_exp;
            m_exp  = hit[ispr_m] ? ispr_wdata_i[7:0]
                   : sl_m_i ? (mode_exp ? m_exp << 1 : m_exp >> 1) : m_exp;
            j2_exp = hit[ispr_j2] ? ispr_wdata_i[7:0]
                   : sl_j2_i ? (mode_exp ? j2_exp >> 1 : j2_exp << 1) : j2_exp;
            j_exp  = hit[ispr_j] ? ispr_wdata_i[7:0] : inc_j_i ? j_exp + 8'd1 : j_exp;
            mode_exp = hit[ispr_mode] ? ispr_wdata_i[0] : mode_exp;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %0s: got %h expected %h", name, got, exp);
            $display("Test failed");
            $fatal(1, "Output check failed");
        end
    endtask

    task automatic check_outputs();
        check_value("wdr0_o", 32'(wdr0_o), 32'(idx0_exp[7:3]));
        check_value("wsel0_o", 32'(wsel0_o), 32'(idx0_exp[2:0]));
        check_value("wdr1_o", 32'(wdr1_o), 32'(idx1_exp[7:3]));
        check_value("wsel1_o", 32'(wsel1_o), 32'(idx1_exp[2:0]));
        check_value("x_o", 32'(x_o), 32'(x_exp));
        check_value("y_o", 32'(y_o), 32'(y_exp));
        check_value("ispr_rdata_o", ispr_rdata_o, expected_rdata(ispr_addr_i));
    endtask

    // One clock: model update at the edge, checks, then the caller drives
    task automatic next_cycle();
        @(posedge clk_i);
        update_model();
        #(drive_delay);
        check_outputs();
    endtask

    task automatic clear_strobes();
        {sl_m_i, sl_j2_i, inc_j_i, set_idx_i, inc_idx_i} = '0;
        {inc_x_i, inc_y_i, ispr_wr_en_i, ispr_init_i} = '0;
    endtask

    task automatic write_reg(input ispr_addr_e addr, input logic [31:0] data);
        clear_strobes();
        ispr_wr_en_i = 1'b1;
        ispr_addr_i  = addr;
        ispr_wdata_i = data;
        next_cycle();
        ispr_wr_en_i = 1'b0;
    endtask

    task automatic read_all();
        clear_strobes();
        for (int a = 0; a < 8; a++) begin
            ispr_addr_i = ispr_addr_e'(a);
            next_cycle();
        end
    endtask

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        clear_strobes();
        ispr_addr_i  = ispr_m;
        ispr_wdata_i = '0;
        {m_exp, j2_exp, j_exp, mode_exp, idx0_exp, idx1_exp, x_exp, y_exp} = '0;
        void'($urandom(32'hdb82));

        repeat (5) next_cycle();
        rst_i = 1'b0;
        read_all();

        // Each register written with full random data, then read back
        for (int a = 0; a < 8; a++) begin
            write_reg(ispr_addr_e'(a), $urandom);
            next_cycle();
        end

        // Strides in both modes, edge bits at each end
        for (int md = 0; md < 2; md++) begin
            write_reg(ispr_mode, 32'(md));
            write_reg(ispr_m, 32'h80);
            write_reg(ispr_j2, 32'h01);
            sl_m_i  = 1'b1;
            sl_j2_i = 1'b1;
            repeat (2) begin
                ispr_addr_i = ispr_m;
                next_cycle();
                ispr_addr_i = ispr_j2;
                next_cycle();
            end
            write_reg(ispr_m, 32'h01);
            write_reg(ispr_j2, 32'h80);
            sl_m_i  = 1'b1;
            sl_j2_i = 1'b1;
            repeat (2) next_cycle();
        end

        // Loop counter wrap, then index setup racing an increment
        write_reg(ispr_j, 32'hfe);
        inc_j_i     = 1'b1;
        ispr_addr_i = ispr_j;
        repeat (3) next_cycle();
        write_reg(ispr_j, 32'h2c);
        write_reg(ispr_m, 32'hf0);
        set_idx_i   = 1'b1;
        inc_idx_i   = 1'b1;
        ispr_addr_i = ispr_idx1;
        next_cycle();
        set_idx_i = 1'b0;
        repeat (2) next_cycle();

        // Coordinates through a full lap and from out-of-range values
        write_reg(ispr_x, 32'h0);
        inc_x_i = 1'b1;
        inc_y_i = 1'b1;
        repeat (6) next_cycle();
        for (int v = 5; v < 8; v++) begin
            write_reg(ispr_x, 32'(v));
            write_reg(ispr_y, 32'(v));
            inc_x_i = 1'b1;
            inc_y_i = 1'b1;
            next_cycle();
        end

        // Write against own operation, then write against init
        clear_strobes();
        ispr_wr_en_i = 1'b1;
        ispr_addr_i  = ispr_m;
        ispr_wdata_i = 32'h5a;
        sl_m_i       = 1'b1;
        next_cycle();
        ispr_addr_i = ispr_x;
        inc_x_i     = 1'b1;
        next_cycle();
        ispr_addr_i = ispr_idx0;
        set_idx_i   = 1'b1;
        next_cycle();
        ispr_addr_i = ispr_j;
        inc_j_i     = 1'b1;
        ispr_init_i = 1'b1;
        next_cycle();
        read_all();

        repeat (random_cycles) begin
            sl_m_i       = ($urandom_range(3) == 0);
            sl_j2_i      = ($urandom_range(3) == 0);
            inc_j_i      = ($urandom_range(3) == 0);
            set_idx_i    = ($urandom_range(3) == 0);
            inc_idx_i    = ($urandom_range(3) == 0);
            inc_x_i      = ($urandom_range(3) == 0);
            inc_y_i      = ($urandom_range(3) == 0);
            ispr_wr_en_i = ($urandom_range(7) == 0);
            ispr_init_i  = ($urandom_range(199) == 0);
            ispr_addr_i  = ispr_addr_e'($urandom_range(7));
            ispr_wdata_i = $urandom;
            next_cycle();
        end

        $display("Test passed");
        $finish;
    end

endmodule

// File: compile.f
logic/ntt_addr_pkg.sv
logic/ispr_bus_if.sv
logic/addr_state_if.sv
logic/ispr_port.sv
logic/loop_regs.sv
logic/index_gen.sv
logic/ntt_addr_unit.sv
sim/ntt_addr_assertions.sv
sim/tb_ntt_addr_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the NTT address unit testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module tb_ntt_addr_unit \
    -f compile.f \
    -Mdir obj_dir -o sim_ntt_addr_unit
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/sim_ntt_addr_unit
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
    exit "$sim_status"
fi

echo "Simulation ended normally"
exit 0
